// ==== all.f ====
logic/xcom_proto_pkg.sv
logic/xcom_bus_pkg.sv
logic/xcom_regs.sv
logic/xcom_mbox_arb.sv
logic/xcom_tx.sv
logic/xcom_rx.sv
logic/xcom_top.sv
tests/xcom_asserts.sv
tests/xcom_checker.sv
tests/xcom_tb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= xcom_tb
FILELIST  ?= all.f
OBJ_DIR   ?= obj_dir
RUNFLAGS  ?= +verilator+error+limit+1000
PASS_MSG  := Regression passed

SIM  := $(OBJ_DIR)/V$(TOP)
SRCS := $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: $(SIM)

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --Mdir $(OBJ_DIR) --top-module $(TOP) -f $(FILELIST)

run: $(SIM)
	@out="$$(./$(SIM) $(RUNFLAGS))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== tests/xcom_tb.sv ====
////////////////////
// testbench top for the serial link controller
// clock, reset, serial loopback, wishbone master tasks
// random frames from an xorshift source and the run timeout
////////////////////
`timescale 1ns/1ps

module xcom_tb;
  import xcom_bus_pkg::*;

  localparam int NFRAMES     = 60;
  // longest frame is 40 bits at 2 x 9 cycles per bit
  localparam int FRAME_CYC   = 40 * 2 * 9;
  // register writes, polling and read back per frame
  localparam int BUS_CYC     = 200;
  localparam int TIMEOUT_CYC = NFRAMES * (FRAME_CYC + BUS_CYC) * 2;

  logic        ps_clk;
  logic        ps_rstn;
  wb_req_t     wb_req;
  wb_rsp_t     wb_rsp;
  logic        xcom_clk;
  logic        xcom_data;
  logic [3:0]  xcom_id;
  logic        sync;
  logic [31:0] rng_state;
  logic [31:0] rdat;
  logic [7:0]  hdr;
  logic [31:0] pick;
  int          cycles;
  int          value_errs;
  int          proto_errs;
  int          frames_done;
  int          assert_fails;

  // serial outputs looped straight back into the receiver
  xcom_top #(
    .RX_SYNC_STAGES (2)
  ) dut_i (
    .i_ps_clk    (ps_clk),
    .i_ps_rstn   (ps_rstn),
    .i_wb        (wb_req),
    .o_wb        (wb_rsp),
    .i_xcom_clk  (xcom_clk),
    .i_xcom_data (xcom_data),
    .o_xcom_clk  (xcom_clk),
    .o_xcom_data (xcom_data),
    .o_xcom_id   (xcom_id),
    .o_sync      (sync)
  );

  xcom_checker chk_i (
    .i_ps_clk     (ps_clk),
    .i_ps_rstn    (ps_rstn),
    .i_wb         (wb_req),
    .i_wb_rsp     (wb_rsp),
    .i_ser_clk    (xcom_clk),
    .i_ser_data   (xcom_data),
    .i_sync       (sync),
    .i_xcom_id    (xcom_id),
    .o_value_errs (value_errs),
    .o_proto_errs (proto_errs),
    .o_frames     (frames_done)
  );

  always #2 ps_clk = ~ps_clk;

  // xorshift32, state advances on every call
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  ////////////////////
  // wishbone master
  ////////////////////
  // held until the ack has been seen by a rising edge, released a half cycle later
  task automatic write_reg(input logic [4:0] adr, input logic [31:0] dat);
    @(negedge ps_clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b1, adr: adr, dat: dat};
    @(negedge ps_clk);
    while (!wb_rsp.ack) @(negedge ps_clk);
    @(negedge ps_clk);
    wb_req = '0;
  endtask

  task automatic read_reg(input logic [4:0] adr, output logic [31:0] dat);
    @(negedge ps_clk);
    wb_req = '{cyc: 1'b1, stb: 1'b1, we: 1'b0, adr: adr, dat: 32'h0};
    @(negedge ps_clk);
    while (!wb_rsp.ack) @(negedge ps_clk);
    dat = wb_rsp.dat;
    @(negedge ps_clk);
    wb_req = '0;
  endtask

  // poll ctrl until busy reads low
  task automatic wait_tx_idle();
    logic [31:0] d;
    d = 32'h1;
    while (d[0]) read_reg(REG_CTRL, d);
  endtask

  // cfg and txdata go in while the previous frame may still be on the wire,
  // so the ctrl write often meets back-pressure
  task automatic send_frame(output logic [7:0] h);
    logic [31:0] r;
    r = next_rand();
    write_reg(REG_CFG, r);
    r = next_rand();
    write_reg(REG_TXDATA, r);
    r = next_rand();
    // occasional writes that must be ignored
    if (r[31:30] == 2'b00) begin
      write_reg({1'b1, r[3:0]}, next_rand());
    end else if (r[31:30] == 2'b01) begin
      write_reg(r[29] ? REG_ID : REG_RXCNT, next_rand());
    end
    r = next_rand();
    h = r[7:0];
    write_reg(REG_CTRL, r);
  endtask

  // the checker compares everything read here
  task automatic read_back(input logic [7:0] h);
    logic [31:0] r;
    wait_tx_idle();
    read_reg({1'b1, h[3:0]}, rdat);
    r = next_rand();
    read_reg({1'b1, r[3:0]}, rdat);
    read_reg(REG_ID, rdat);
    read_reg(REG_RXCNT, rdat);
    read_reg(REG_CFG, rdat);
    read_reg(REG_TXDATA, rdat);
  endtask

  // run limit
  always @(posedge ps_clk) begin
    cycles++;
    if (cycles >= TIMEOUT_CYC) begin
      $display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
      $display("Regression failed");
      $finish;
    end
  end

  initial begin
    ps_clk    = 1'b0;
    ps_rstn   = 1'b0;
    wb_req    = '0;
    rng_state = 32'd92538;
    cycles    = 0;
    repeat (10) @(posedge ps_clk);
    @(negedge ps_clk);
    ps_rstn = 1'b1;

    for (int f = 0; f < NFRAMES; f++) begin
      send_frame(hdr);
      pick = next_rand();
      if (pick[1:0] == 2'd0) begin
        read_back(hdr);
      end
    end
    read_back(hdr);

    assert_fails = dut_i.asserts_i.fails;
    $display("summary: %0d value errors, %0d protocol errors, %0d assertion failures, %s",
             value_errs, proto_errs, assert_fails,
             $sformatf("%0d of %0d frames", frames_done, NFRAMES));
    if (value_errs == 0 && proto_errs == 0 && assert_fails == 0 &&
        frames_done == NFRAMES) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

// ==== tests/xcom_checker.sv ====
////////////////////
// reference model and scoreboard
// follows bus writes, serial pins, sync and board id
// compares register reads and serial frames
////////////////////
`timescale 1ns/1ps

module xcom_checker (
  input  logic                  i_ps_clk,
  input  logic                  i_ps_rstn,
  input  xcom_bus_pkg::wb_req_t i_wb,
  input  xcom_bus_pkg::wb_rsp_t i_wb_rsp,
  input  logic                  i_ser_clk,
  input  logic                  i_ser_data,
  input  logic                  i_sync,
  input  logic [3:0]            i_xcom_id,
  output int                    o_value_errs,
  output int                    o_proto_errs,
  output int                    o_frames
);
  import xcom_bus_pkg::*;

  localparam int RUN_CAP = 1000;

  // model state
  logic [2:0]  tick_m;
  logic [2:0]  cur_tick;
  logic [31:0] txdata_m;
  logic [31:0] mbox_m [16];
  logic [3:0]  id_m;
  logic [15:0] cnt_m;
  int          sync_exp;
  int          sync_seen;
  // frame on the wire
  logic        bits_q [$];
  logic [7:0]  cur_hdr;
  logic [31:0] cur_data;
  // pin history
  logic        clk_prev;
  logic        sync_prev;
  logic        exp_bit;
  int          run;

  // length code 0..3 means 0, 8, 16, 32 data bits
  function automatic int payload_bits(input logic [1:0] len);
    case (len)
      2'd1:    return 8;
      2'd2:    return 16;
      2'd3:    return 32;
      default: return 0;
    endcase
  endfunction

  function automatic logic [31:0] payload_mask(input int n);
    if (n >= 32) begin
      return 32'hffff_ffff;
    end
    return (32'h1 << n) - 32'h1;
  endfunction

  task automatic compare_value(input string name, input logic [31:0] got,
                               input logic [31:0] exp);
    if (got !== exp) begin
      $display("error %s got 0x%08h exp 0x%08h", name, got, exp);
      o_value_errs++;
    end
  endtask

  task automatic protocol_fault(input string what);
    $display("%s", what);
    o_proto_errs++;
  endtask

  ////////////////////
  // frame bookkeeping
  ////////////////////
  task automatic start_frame(input logic [7:0] h, input logic [31:0] d);
    int n;
    if (bits_q.size() != 0) begin
      protocol_fault("ctrl write acked before the previous frame was fully sent");
    end
    // busy drops tick+2 cycles past the last fall, ack comes after that
    if (i_ser_clk || run < int'(cur_tick) + 4) begin
      protocol_fault("ctrl write acked while the transmitter was still busy");
    end
    cur_hdr  = h;
    cur_data = d;
    cur_tick = tick_m;
    bits_q.delete();
    for (int i = 7; i >= 0; i--) begin
      bits_q.push_back(h[i]);
    end
    n = payload_bits(h[6:5]);
    for (int i = n - 1; i >= 0; i--) begin
      bits_q.push_back(d[i]);
    end
    // transmitter starts one cycle after the ack
    run = 0;
  endtask

  // receiver effects of a completed frame
  task automatic finish_frame();
    int n;
    n = payload_bits(cur_hdr[6:5]);
    o_frames++;
    cnt_m = cnt_m + 16'd1;
    if (cur_hdr[7]) begin
      sync_exp++;
    end
    if (cur_hdr[4]) begin
      id_m = cur_hdr[3:0];
    end else if (n != 0) begin
      mbox_m[cur_hdr[3:0]] = cur_data & payload_mask(n);
    end
  endtask

  task automatic check_read(input logic [4:0] adr, input logic [31:0] dat);
    case (adr)
      REG_CTRL: begin
        // idle means every frame and its receiver effects are done
        if (!dat[0]) begin
          if (bits_q.size() != 0) begin
            protocol_fault("transmitter reported idle with frame bits still pending");
          end
          compare_value("o_sync pulses", 32'(sync_seen), 32'(sync_exp));
          compare_value("o_xcom_id", {28'h0, i_xcom_id}, {28'h0, id_m});
        end
      end
      REG_CFG:    compare_value("o_wb.dat cfg", dat, {29'h0, tick_m});
      REG_TXDATA: compare_value("o_wb.dat txdata", dat, txdata_m);
      REG_ID:     compare_value("o_wb.dat id", dat, {28'h0, id_m});
      REG_RXCNT:  compare_value("o_wb.dat rxcnt", dat, {16'h0, cnt_m});
      default: begin
        if (adr >= REG_MBOX_BASE) begin
          compare_value("o_wb.dat mbox", dat, mbox_m[adr[3:0]]);
        end
      end
    endcase
  endtask

  ////////////////////
  // sampling
  ////////////////////
  // rising edge sees the values of the cycle just ending
  always @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      tick_m       = '0;
      cur_tick     = '0;
      txdata_m     = '0;
      id_m         = '0;
      cnt_m        = '0;
      sync_exp     = 0;
      sync_seen    = 0;
      o_value_errs = 0;
      o_proto_errs = 0;
      o_frames     = 0;
      for (int i = 0; i < 16; i++) begin
        mbox_m[i] = '0;
      end
      bits_q.delete();
      clk_prev  = 1'b0;
      sync_prev = 1'b0;
      run       = RUN_CAP;
    end else begin
      // serial clock phases and data bits
      if (i_ser_clk != clk_prev) begin
        compare_value("o_xcom_clk phase", 32'(run), 32'(cur_tick) + 32'd2);
        run = 1;
        if (i_ser_clk) begin
          if (bits_q.size() == 0) begin
            protocol_fault("serial clock rose with no frame in progress");
          end else begin
            exp_bit = bits_q.pop_front();
            compare_value("o_xcom_data", {31'h0, i_ser_data}, {31'h0, exp_bit});
            if (bits_q.size() == 0) begin
              finish_frame();
            end
          end
        end
      end else if (run < RUN_CAP) begin
        run++;
      end
      clk_prev = i_ser_clk;
      // sync must be single cycle pulses
      if (i_sync) begin
        sync_seen++;
        if (sync_prev) begin
          protocol_fault("o_sync stayed high for more than one cycle");
        end
      end
      sync_prev = i_sync;
      // completed bus transfers
      if (i_wb_rsp.ack) begin
        if (i_wb.we) begin
          case (i_wb.adr)
            REG_CTRL:   start_frame(i_wb.dat[7:0], txdata_m);
            REG_CFG:    tick_m = i_wb.dat[2:0];
            REG_TXDATA: txdata_m = i_wb.dat;
            default:    ;
          endcase
        end else begin
          check_read(i_wb.adr, i_wb_rsp.dat);
        end
      end
    end
  end

endmodule

// ==== tests/xcom_asserts.sv ====
////////////////////
// concurrent assertions on wishbone and serial pins
// bound into the top level
////////////////////
`timescale 1ns/1ps

module xcom_asserts (
  input logic                  i_ps_clk,
  input logic                  i_ps_rstn,
  input xcom_bus_pkg::wb_req_t i_wb,
  input xcom_bus_pkg::wb_rsp_t i_wb_rsp,
  input logic                  i_ser_clk,
  input logic                  i_ser_data
);
  int fails = 0;

  ack_in_cycle: assert property (@(posedge i_ps_clk) disable iff (!i_ps_rstn)
    i_wb_rsp.ack |-> (i_wb.cyc && i_wb.stb))
    else begin $error("wishbone ack without cyc and stb"); fails++; end

  ack_single: assert property (@(posedge i_ps_clk) disable iff (!i_ps_rstn)
    i_wb_rsp.ack |=> !i_wb_rsp.ack)
    else begin $error("wishbone ack held for two cycles"); fails++; end

  // data only moves with the falling serial edge
  data_stable_high: assert property (@(posedge i_ps_clk) disable iff (!i_ps_rstn)
    (i_ser_clk && $past(i_ser_clk)) |-> (i_ser_data == $past(i_ser_data)))
    else begin $error("serial data changed while serial clock was high"); fails++; end

  idle_after_reset: assert property (@(posedge i_ps_clk)
    $rose(i_ps_rstn) |-> (!i_ser_clk && !i_ser_data))
    else begin $error("serial outputs not low after reset"); fails++; end

endmodule

bind xcom_top xcom_asserts asserts_i (
  .i_ps_clk   (i_ps_clk),
  .i_ps_rstn  (i_ps_rstn),
  .i_wb       (i_wb),
  .i_wb_rsp   (o_wb),
  .i_ser_clk  (o_xcom_clk),
  .i_ser_data (o_xcom_data)
);

// ==== logic/xcom_top.sv ====
////////////////////
// serial link controller top level
// register file, mailbox arbiter, transmitter, receiver
////////////////////
`timescale 1ns/1ps

module xcom_top #(
  parameter int RX_SYNC_STAGES = 2
) (
  input  logic                  i_ps_clk,
  input  logic                  i_ps_rstn,
  input  xcom_bus_pkg::wb_req_t i_wb,
  output xcom_bus_pkg::wb_rsp_t o_wb,
  input  logic                  i_xcom_clk,
  input  logic                  i_xcom_data,
  output logic                  o_xcom_clk,
  output logic                  o_xcom_data,
  output logic [3:0]            o_xcom_id,
  output logic                  o_sync
);
  import xcom_bus_pkg::*;
  import xcom_proto_pkg::*;

  // transmit handoff
  logic                   tx_start;
  xcom_hdr_u              tx_hdr;
  logic [XCOM_DATA_W-1:0] tx_data;
  logic [XCOM_TICK_W-1:0] tick;
  logic                   tx_busy;
  // mailbox ports
  mbox_rd_t               mbox_rd;
  logic                   mbox_rd_ack;
  logic [WB_DAT_W-1:0]    mbox_rd_data;
  mbox_wr_t               mbox_wr;
  logic                   mbox_wr_gnt;
  logic [15:0]            rx_count;

  xcom_regs regs_i (
    .i_ps_clk       (i_ps_clk),
    .i_ps_rstn      (i_ps_rstn),
    .i_wb           (i_wb),
    .o_wb           (o_wb),
    .o_tx_start     (tx_start),
    .o_tx_hdr       (tx_hdr),
    .o_tx_data      (tx_data),
    .o_tick         (tick),
    .i_tx_busy      (tx_busy),
    .o_mbox_rd      (mbox_rd),
    .i_mbox_rd_ack  (mbox_rd_ack),
    .i_mbox_rd_data (mbox_rd_data),
    .i_xcom_id      (o_xcom_id),
    .i_rx_count     (rx_count)
  );

  xcom_mbox_arb arb_i (
    .i_ps_clk       (i_ps_clk),
    .i_ps_rstn      (i_ps_rstn),
    .i_mbox_wr      (mbox_wr),
    .o_mbox_wr_gnt  (mbox_wr_gnt),
    .i_mbox_rd      (mbox_rd),
    .o_mbox_rd_ack  (mbox_rd_ack),
    .o_mbox_rd_data (mbox_rd_data)
  );

  xcom_tx tx_i (
    .i_ps_clk    (i_ps_clk),
    .i_ps_rstn   (i_ps_rstn),
    .i_tx_start  (tx_start),
    .i_tx_hdr    (tx_hdr),
    .i_tx_data   (tx_data),
    .i_tick      (tick),
    .o_tx_busy   (tx_busy),
    .o_xcom_clk  (o_xcom_clk),
    .o_xcom_data (o_xcom_data)
  );

  xcom_rx #(
    .RX_SYNC_STAGES (RX_SYNC_STAGES)
  ) rx_i (
    .i_ps_clk      (i_ps_clk),
    .i_ps_rstn     (i_ps_rstn),
    .i_xcom_clk    (i_xcom_clk),
    .i_xcom_data   (i_xcom_data),
    .o_mbox_wr     (mbox_wr),
    .i_mbox_wr_gnt (mbox_wr_gnt),
    .o_xcom_id     (o_xcom_id),
    .o_sync        (o_sync),
    .o_rx_count    (rx_count)
  );

endmodule

// ==== logic/xcom_rx.sv ====
////////////////////
// input synchronizer and frame deserializer
// header decode as mailbox write or board id
// received frame counter and sync pulse
////////////////////
`timescale 1ns/1ps

module xcom_rx #(
  parameter int RX_SYNC_STAGES = 2
) (
  input  logic                   i_ps_clk,
  input  logic                   i_ps_rstn,
  input  logic                   i_xcom_clk,
  input  logic                   i_xcom_data,
  output xcom_bus_pkg::mbox_wr_t o_mbox_wr,
  input  logic                   i_mbox_wr_gnt,
  output logic [3:0]             o_xcom_id,
  output logic                   o_sync,
  output logic [15:0]            o_rx_count
);
  import xcom_proto_pkg::*;

  logic [RX_SYNC_STAGES-1:0] clk_sync;
  logic [RX_SYNC_STAGES-1:0] data_sync;
  logic                      clk_prev;
  logic                      rise;
  logic                      bit_in;
  logic                      last;
  logic                      post;
  logic [XCOM_BCNT_W-1:0]    bcnt;
  xcom_hdr_u                 hdr_q;
  xcom_hdr_u                 hdr_shift;
  xcom_hdr_u                 hdr_view;
  logic [XCOM_DATA_W-1:0]    data_q;
  logic [XCOM_DATA_W-1:0]    data_shift;
  logic                      wr_valid_q;
  logic [3:0]                wr_idx_q;
  logic [XCOM_DATA_W-1:0]    wr_data_q;

  ////////////////////
  // edge detect and bit assembly
  ////////////////////
  assign rise   = clk_sync[RX_SYNC_STAGES-1] & ~clk_prev;
  assign bit_in = data_sync[RX_SYNC_STAGES-1];

  assign hdr_shift  = xcom_hdr_u'({hdr_q[XCOM_HDR_BITS-2:0], bit_in});
  assign data_shift = {data_q[XCOM_DATA_W-2:0], bit_in};
  // while the header is still coming in, look at it with the new bit added
  assign hdr_view   = (bcnt < XCOM_HDR_BITS) ? hdr_shift : hdr_q;

  // partial headers never reach the 8 bit minimum, so no false end
  assign last = rise & ((bcnt + 1'b1) == xcom_frame_bits(hdr_view.mbox.len));
  assign post = last & (hdr_view.mbox.kind == KIND_MBOX) &
                (hdr_view.mbox.len != LEN_NONE);

  assign o_mbox_wr = '{valid: wr_valid_q, idx: wr_idx_q, data: wr_data_q};

  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      clk_sync   <= '0;
      data_sync  <= '0;
      clk_prev   <= 1'b0;
      bcnt       <= '0;
      hdr_q      <= '0;
      o_sync     <= 1'b0;
      o_xcom_id  <= '0;
      o_rx_count <= '0;
      wr_valid_q <= 1'b0;
    end else begin
      clk_sync  <= RX_SYNC_STAGES'({clk_sync, i_xcom_clk});
      data_sync <= RX_SYNC_STAGES'({data_sync, i_xcom_data});
      clk_prev  <= clk_sync[RX_SYNC_STAGES-1];
      if (last) begin
        bcnt <= '0;
      end else if (rise) begin
        bcnt <= bcnt + 1'b1;
      end
      if (rise && bcnt < XCOM_HDR_BITS) begin
        hdr_q <= hdr_shift;
      end
      ////////////////////
      // frame end actions
      ////////////////////
      o_sync <= last & hdr_view.mbox.sync;
      if (last) begin
        o_rx_count <= o_rx_count + 1'b1;
      end
      if (last && hdr_view.id.kind == KIND_ID) begin
        o_xcom_id <= hdr_view.id.id;
      end
      // posted write stays up until the arbiter takes it
      if (post) begin
        wr_valid_q <= 1'b1;
      end else if (i_mbox_wr_gnt) begin
        wr_valid_q <= 1'b0;
      end
    end
  end

  // data bits, cleared at the first header bit for zero extension
  always_ff @(posedge i_ps_clk) begin
    if (rise && bcnt < XCOM_HDR_BITS) begin
      if (bcnt == '0) begin
        data_q <= '0;
      end
    end else if (rise) begin
      data_q <= data_shift;
    end
    if (post) begin
      wr_idx_q  <= hdr_view.mbox.idx;
      wr_data_q <= data_shift;
    end
  end

endmodule

// ==== logic/xcom_tx.sv ====
////////////////////
// frame serializer
// header then 0/8/16/32 data bits, msb first
// serial clock half period is tick + 2 cycles
////////////////////
`timescale 1ns/1ps

module xcom_tx (
  input  logic                                   i_ps_clk,
  input  logic                                   i_ps_rstn,
  input  logic                                   i_tx_start,
  input  xcom_proto_pkg::xcom_hdr_u              i_tx_hdr,
  input  logic [xcom_proto_pkg::XCOM_DATA_W-1:0] i_tx_data,
  input  logic [xcom_proto_pkg::XCOM_TICK_W-1:0] i_tick,
  output logic                                   o_tx_busy,
  output logic                                   o_xcom_clk,
  output logic                                   o_xcom_data
);
  import xcom_proto_pkg::*;

  localparam int FRAME_W = XCOM_HDR_BITS + XCOM_DATA_W;

  typedef enum logic [1:0] {
    S_IDLE,
    S_BIT,
    S_TAIL
  } tx_state_e;

  tx_state_e              state;
  logic [XCOM_TICK_W-1:0] tick_q;
  logic [XCOM_TICK_W:0]   hc;
  logic                   hc_end;
  logic [FRAME_W-1:0]     sh;
  logic [FRAME_W-1:0]     frame;
  logic [XCOM_DATA_W-1:0] payload;
  logic [XCOM_BCNT_W-1:0] fbits;
  logic [XCOM_BCNT_W-1:0] bits_left;
  logic                   fall;

  // left align the used data bits under the header
  always_comb begin
    fbits = xcom_frame_bits(i_tx_hdr.mbox.len);
    case (i_tx_hdr.mbox.len)
      LEN_8:   payload = {i_tx_data[7:0], 24'h0};
      LEN_16:  payload = {i_tx_data[15:0], 16'h0};
      LEN_32:  payload = i_tx_data;
      default: payload = '0;
    endcase
    frame = {i_tx_hdr, payload};
  end

  // end of a half period
  assign hc_end = (hc == {1'b0, tick_q} + 1'b1);
  // falling serial edge, next bit goes out here
  assign fall   = (state == S_BIT) & hc_end & o_xcom_clk;

  ////////////////////
  // serial clock and bit FSM
  ////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      state       <= S_IDLE;
      tick_q      <= '0;
      hc          <= '0;
      bits_left   <= '0;
      o_tx_busy   <= 1'b0;
      o_xcom_clk  <= 1'b0;
      o_xcom_data <= 1'b0;
    end else begin
      case (state)
        S_IDLE: begin
          if (i_tx_start) begin
            // first bit is set up one half period before the first rise
            state       <= S_BIT;
            tick_q      <= i_tick;
            hc          <= '0;
            bits_left   <= fbits;
            o_tx_busy   <= 1'b1;
            o_xcom_data <= frame[FRAME_W-1];
          end
        end
        S_BIT: begin
          if (hc_end) begin
            hc         <= '0;
            o_xcom_clk <= ~o_xcom_clk;
            if (o_xcom_clk) begin
              if (bits_left == 1) begin
                // last bit done, line back to idle level
                o_xcom_data <= 1'b0;
                state       <= S_TAIL;
              end else begin
                o_xcom_data <= sh[FRAME_W-2];
                bits_left   <= bits_left - 1'b1;
              end
            end
          end else begin
            hc <= hc + 1'b1;
          end
        end
        default: begin
          // one more half period before busy drops
          if (hc_end) begin
            hc        <= '0;
            state     <= S_IDLE;
            o_tx_busy <= 1'b0;
          end else begin
            hc <= hc + 1'b1;
          end
        end
      endcase
    end
  end

  // frame shift register, msb is the bit on the wire
  always_ff @(posedge i_ps_clk) begin
    if (state == S_IDLE && i_tx_start) begin
      sh <= frame;
    end else if (fall) begin
      sh <= sh << 1;
    end
  end

endmodule

// ==== logic/xcom_mbox_arb.sv ====
////////////////////
// 16 word mailbox memory
// fixed priority: receiver write over host read
////////////////////
`timescale 1ns/1ps

module xcom_mbox_arb (
  input  logic                   i_ps_clk,
  input  logic                   i_ps_rstn,
  input  xcom_bus_pkg::mbox_wr_t i_mbox_wr,
  output logic                   o_mbox_wr_gnt,
  input  xcom_bus_pkg::mbox_rd_t i_mbox_rd,
  output logic                   o_mbox_rd_ack,
  output logic [31:0]            o_mbox_rd_data
);
  import xcom_bus_pkg::*;

  logic [WB_DAT_W-1:0] mem [MBOX_DEPTH];
  logic                rd_gnt;
  logic                rd_ack_q;
  logic [WB_DAT_W-1:0] rd_data_q;

  ////////////////////
  // grant logic
  ////////////////////
  // the answer cycle of a read takes the slot, nothing else is granted then
  assign o_mbox_wr_gnt = i_mbox_wr.valid & ~rd_ack_q;
  // read waits for any competing receiver write
  assign rd_gnt        = i_mbox_rd.valid & ~i_mbox_wr.valid & ~rd_ack_q;

  assign o_mbox_rd_ack  = rd_ack_q;
  assign o_mbox_rd_data = rd_data_q;

  // mailbox contents, cleared at reset
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      for (int i = 0; i < MBOX_DEPTH; i++) begin
        mem[i] <= '0;
      end
    end else if (o_mbox_wr_gnt) begin
      mem[i_mbox_wr.idx] <= i_mbox_wr.data;
    end
  end

  // one stage read pipeline, ack is a single pulse per grant
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      rd_ack_q <= 1'b0;
    end else begin
      rd_ack_q <= rd_gnt;
    end
  end

  always_ff @(posedge i_ps_clk) begin
    if (rd_gnt) begin
      rd_data_q <= mem[i_mbox_rd.idx];
    end
  end

endmodule

// ==== logic/xcom_regs.sv ====
////////////////////
// wishbone slave register file
// cfg and txdata registers, ctrl write launches a frame
// mailbox window reads go through the arbiter
////////////////////
`timescale 1ns/1ps

module xcom_regs (
  input  logic                                   i_ps_clk,
  input  logic                                   i_ps_rstn,
  input  xcom_bus_pkg::wb_req_t                  i_wb,
  output xcom_bus_pkg::wb_rsp_t                  o_wb,
  output logic                                   o_tx_start,
  output xcom_proto_pkg::xcom_hdr_u              o_tx_hdr,
  output logic [xcom_proto_pkg::XCOM_DATA_W-1:0] o_tx_data,
  output logic [xcom_proto_pkg::XCOM_TICK_W-1:0] o_tick,
  input  logic                                   i_tx_busy,
  output xcom_bus_pkg::mbox_rd_t                 o_mbox_rd,
  input  logic                                   i_mbox_rd_ack,
  input  logic [31:0]                            i_mbox_rd_data,
  input  logic [3:0]                             i_xcom_id,
  input  logic [15:0]                            i_rx_count
);
  import xcom_bus_pkg::*;
  import xcom_proto_pkg::*;

  logic                  ack_q;
  logic [WB_DAT_W-1:0]   rdat_q;
  logic [WB_DAT_W-1:0]   rdat_mux;
  logic                  rd_valid_q;
  logic [MBOX_IDX_W-1:0] rd_idx_q;
  logic                  req;
  logic                  is_mbox;
  logic                  is_ctrl;
  logic                  ctrl_stall;
  logic                  tx_go;
  logic                  mbox_rd_req;
  logic                  simple_ack;

  ////////////////////
  // request decode
  ////////////////////
  // new transfer only once the previous one is acked and no mailbox read is open
  assign req         = i_wb.cyc & i_wb.stb & ~o_wb.ack & ~rd_valid_q;
  assign is_mbox     = (i_wb.adr >= REG_MBOX_BASE);
  assign is_ctrl     = (i_wb.adr == REG_CTRL);
  // ctrl write holds off while a frame is on the wire
  assign ctrl_stall  = i_wb.we & is_ctrl & i_tx_busy;
  assign tx_go       = req & i_wb.we & is_ctrl & ~i_tx_busy;
  assign mbox_rd_req = req & ~i_wb.we & is_mbox;
  // everything else is answered on the next cycle
  assign simple_ack  = req & ~(~i_wb.we & is_mbox) & ~ctrl_stall;

  // mailbox data is forwarded straight from the arbiter
  assign o_wb = '{ack: ack_q | i_mbox_rd_ack,
                  dat: i_mbox_rd_ack ? i_mbox_rd_data : rdat_q};

  assign o_mbox_rd = '{valid: rd_valid_q, idx: rd_idx_q};

  // register read mux
  always_comb begin
    case (i_wb.adr)
      REG_CTRL:   rdat_mux = {{(WB_DAT_W-1){1'b0}}, i_tx_busy};
      REG_CFG:    rdat_mux = {{(WB_DAT_W-XCOM_TICK_W){1'b0}}, o_tick};
      REG_TXDATA: rdat_mux = o_tx_data;
      REG_ID:     rdat_mux = {28'h0, i_xcom_id};
      REG_RXCNT:  rdat_mux = {16'h0, i_rx_count};
      default:    rdat_mux = '0;
    endcase
  end

  ////////////////////
  // control and host registers
  ////////////////////
  always_ff @(posedge i_ps_clk) begin
    if (!i_ps_rstn) begin
      ack_q      <= 1'b0;
      o_tx_start <= 1'b0;
      o_tick     <= '0;
      o_tx_data  <= '0;
      rd_valid_q <= 1'b0;
    end else begin
      ack_q      <= simple_ack;
      o_tx_start <= tx_go;
      if (req && i_wb.we && i_wb.adr == REG_CFG) begin
        o_tick <= i_wb.dat[XCOM_TICK_W-1:0];
      end
      if (req && i_wb.we && i_wb.adr == REG_TXDATA) begin
        o_tx_data <= i_wb.dat;
      end
      // open a mailbox read, close it when the arbiter answers
      if (mbox_rd_req) begin
        rd_valid_q <= 1'b1;
      end else if (i_mbox_rd_ack) begin
        rd_valid_q <= 1'b0;
      end
    end
  end

  // payload, only meaningful alongside its strobe
  always_ff @(posedge i_ps_clk) begin
    if (tx_go) begin
      o_tx_hdr <= xcom_hdr_u'(i_wb.dat[XCOM_HDR_BITS-1:0]);
    end
    if (mbox_rd_req) begin
      rd_idx_q <= i_wb.adr[MBOX_IDX_W-1:0];
    end
    if (req && !i_wb.we) begin
      rdat_q <= rdat_mux;
    end
  end

endmodule

// ==== logic/xcom_bus_pkg.sv ====
////////////////////
// host side bus definitions
// wishbone request and response, register map
// mailbox read and write port structs
////////////////////
package xcom_bus_pkg;

  localparam int WB_ADR_W    = 5;
  localparam int WB_DAT_W    = 32;
  localparam int MBOX_IDX_W  = 4;
  localparam int MBOX_DEPTH  = 16;

  // word addresses
  localparam logic [WB_ADR_W-1:0] REG_CTRL      = 5'd0;
  localparam logic [WB_ADR_W-1:0] REG_CFG       = 5'd1;
  localparam logic [WB_ADR_W-1:0] REG_TXDATA    = 5'd2;
  localparam logic [WB_ADR_W-1:0] REG_ID        = 5'd3;
  localparam logic [WB_ADR_W-1:0] REG_RXCNT     = 5'd4;
  // 16..31 map onto mailbox words 0..15
  localparam logic [WB_ADR_W-1:0] REG_MBOX_BASE = 5'd16;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [WB_ADR_W-1:0] adr;
    logic [WB_DAT_W-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic                ack;
    logic [WB_DAT_W-1:0] dat;
  } wb_rsp_t;

  // receiver write, held until granted
  typedef struct packed {
    logic                  valid;
    logic [MBOX_IDX_W-1:0] idx;
    logic [WB_DAT_W-1:0]   data;
  } mbox_wr_t;

  // host read, held until answered
  typedef struct packed {
    logic                  valid;
    logic [MBOX_IDX_W-1:0] idx;
  } mbox_rd_t;

endpackage

// ==== logic/xcom_proto_pkg.sv ====
////////////////////
// serial link protocol definitions
// header byte union with mailbox and board id views
// length codes, tick width and frame bit counts
////////////////////
package xcom_proto_pkg;

  // half period of the serial clock is tick + 2 cycles
  localparam int XCOM_TICK_W   = 3;
  localparam int XCOM_HDR_BITS = 8;
  localparam int XCOM_DATA_W   = 32;
  // bit counters span header plus the longest payload (40 bits)
  localparam int XCOM_BCNT_W   = 6;

  localparam logic KIND_MBOX = 1'b0;
  localparam logic KIND_ID   = 1'b1;

  // payload length carried in header bits 6:5
  typedef enum logic [1:0] {
    LEN_NONE = 2'd0,
    LEN_8    = 2'd1,
    LEN_16   = 2'd2,
    LEN_32   = 2'd3
  } xcom_len_e;

  // kind 0: low nibble selects a mailbox word
  typedef struct packed {
    logic      sync;
    xcom_len_e len;
    logic      kind;
    logic [3:0] idx;
  } xcom_hdr_mbox_t;

  // kind 1: low nibble is the new board id
  typedef struct packed {
    logic      sync;
    xcom_len_e len;
    logic      kind;
    logic [3:0] id;
  } xcom_hdr_id_t;

  typedef union packed {
    xcom_hdr_mbox_t mbox;
    xcom_hdr_id_t   id;
  } xcom_hdr_u;

  // total serial bits of a frame, header included
  function automatic logic [XCOM_BCNT_W-1:0] xcom_frame_bits(xcom_len_e len);
    case (len)
      LEN_8:   return 6'd16;
      LEN_16:  return 6'd24;
      LEN_32:  return 6'd40;
      default: return 6'd8;
    endcase
  endfunction

endpackage
